// File: dec_4b3b.sv
/* 4b/3b sub-block decoder: maps fghj back to HGF, with the K28
   variants, and reports validity and sub-block disparity */
`timescale 1ns/1ns
`default_nettype none

module dec_4b3b (
  input  logic [3:0] code4,
  input  logic       is_k28,
  output logic [2:0] data3,
  output logic       valid,
  output logic [1:0] disp
);
  import elink_pkg::*;

  logic [3:0] cand;
  logic [2:0] ones;

  assign ones = 3'($countones(code4));

  always_comb begin
    data3 = '0;
    valid = 1'b0;
    for (int i = 0; i < 8; i++) begin
      cand = code4_table[i];
      if (is_k28 && (i inside {1, 2, 5, 6})) begin
        cand = ~cand;  // K-form of the balanced codes
      end
      if ((code4 == cand) || (code4 == pos_code4(cand))) begin
        data3 = i[2:0];
        valid = 1'b1;
      end
    end
    if (is_k28 && ((code4 == code4_alt7) || (code4 == ~code4_alt7))) begin
      data3 = 3'd7;
      valid = 1'b1;
    end
  end

  assign disp = (ones == 3'd2) ? disp_zero : (ones > 3'd2) ? disp_pos : disp_neg;

endmodule

`default_nettype wire

// File: dec_6b5b.sv
/* 6b/5b sub-block decoder: maps abcdei back to EDCBA and reports
   validity and sub-block disparity */
`timescale 1ns/1ns
`default_nettype none

module dec_6b5b (
  input  logic [5:0] code6,
  output logic [4:0] data5,
  output logic       valid,
  output logic [1:0] disp
);
  import elink_pkg::*;

  logic [2:0] ones;

  assign ones = 3'($countones(code6));

  // Either table form may appear, depending on running disparity
  always_comb begin
    data5 = '0;
    valid = 1'b0;
    for (int i = 0; i < 32; i++) begin
      if ((code6 == code6_table[i]) || (code6 == pos_code6(code6_table[i]))) begin
        data5 = i[4:0];
        valid = 1'b1;
      end
    end
  end

  always_comb begin
    if (ones == 3'd3) begin
      disp = disp_zero;
    end else if (ones > 3'd3) begin
      disp = disp_pos;   // Also covers illegal 5 and 6 ones
    end else begin
      disp = disp_neg;
    end
  end

endmodule

`default_nettype wire

// File: elink_deser.sv
/* e-link deserializer: shifts in 2-bit words, aligns on K28.5 commas
   and strobes out 10-bit symbols */
`timescale 1ns/1ns
`default_nettype none

module elink_deser (
  input  logic              bit_clk,
  input  logic              rst_n,
  input  logic [1:0]        rx_2bit,   // Bit 1 arrives first
  output elink_pkg::sym10_t sym,
  output logic              sym_valid,
  output logic              locked
);
  import elink_pkg::*;

  logic [8:0]  hist_q;   // Older bits, bit 8 oldest
  logic [10:0] hist;     // History including the pair arriving now
  sym10_t      win0;     // Symbol ending on rx_2bit[0]
  sym10_t      win1;     // Symbol ending on rx_2bit[1]
  logic        comma0;
  logic        comma1;
  logic        phase_q;
  logic [2:0]  cnt_q;
  logic        take;
  logic        sel1;

  assign hist = {hist_q, rx_2bit};
  assign win0 = hist[9:0];
  assign win1 = hist[10:1];

  // Comma sits in abcdeif of the symbol, either polarity
  assign comma0 = (win0[9:3] == comma_pattern) || (win0[9:3] == ~comma_pattern);
  assign comma1 = (win1[9:3] == comma_pattern) || (win1[9:3] == ~comma_pattern);

  assign take = locked ? (cnt_q == 3'd4) : (comma0 || comma1);
  assign sel1 = locked ? phase_q : !comma0;

  always_ff @(posedge bit_clk or negedge rst_n) begin
    if (!rst_n) begin
      hist_q    <= '0;
      locked    <= 1'b0;
      phase_q   <= 1'b0;
      cnt_q     <= '0;
      sym_valid <= 1'b0;
    end else begin
      hist_q    <= hist[8:0];
      sym_valid <= take;
      if (!locked) begin
        if (comma0 || comma1) begin
          locked  <= 1'b1;   // First comma fixes the phase for good
          phase_q <= !comma0;
          cnt_q   <= '0;
        end
      end else if (cnt_q == 3'd4) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 3'd1;
      end
    end
  end

  always_ff @(posedge bit_clk) begin
    if (take) begin
      sym <= sel1 ? win1 : win0;
    end
  end

  a_sym_spacing: assert property (@(posedge bit_clk) disable iff (!rst_n)
    sym_valid |=> !sym_valid [*4]);

endmodule

`default_nettype wire

// File: elink_pkg.sv
/* e-link line coding: 8b10b symbol type, sub-block code tables,
   K-code constants and the decoded-symbol record */
`default_nettype none

package elink_pkg;

  typedef logic [9:0] sym10_t;  // Bit 9 = a, sent first, bit 0 = j

  // 5b/6b codes (abcdei) for negative running disparity
  localparam logic [5:0] code6_table [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001,
    6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100,
    6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010,
    6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110,
    6'b001110, 6'b101110, 6'b011110, 6'b101011
  };

  // 3b/4b codes (fghj) for negative running disparity, entry 7 is P7
  localparam logic [3:0] code4_table [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
  };
  localparam logic [3:0] code4_alt7 = 4'b0111;  // A7, used by K28.7

  // Positive form flips unbalanced codes and the 111000 and 1100 specials
  function automatic logic [5:0] pos_code6(input logic [5:0] c);
    return (($countones(c) != 3) || (c == 6'b111000)) ? ~c : c;
  endfunction

  function automatic logic [3:0] pos_code4(input logic [3:0] c);
    return (($countones(c) != 2) || (c == 4'b1100)) ? ~c : c;
  endfunction

  localparam sym10_t k28_5_neg = 10'b001111_1010;  // Idle comma
  localparam sym10_t k28_1_neg = 10'b001111_1001;  // Start of frame
  localparam sym10_t k28_6_neg = 10'b001111_0110;  // End of frame
  localparam logic [6:0] comma_pattern = 7'b0011111;

  localparam logic [7:0] k28_1_val = 8'h3C;
  localparam logic [7:0] k28_6_val = 8'hDC;

  // Sub-block disparity as reported by the decoders
  localparam logic [1:0] disp_zero = 2'b00;
  localparam logic [1:0] disp_pos  = 2'b01;
  localparam logic [1:0] disp_neg  = 2'b10;

  typedef struct packed {
    logic [7:0] data;
    logic       is_k;
    logic       code_err;
    logic       disp_err;
  } dec_sym_t;

endpackage

`default_nettype wire

// File: elink_rx_checker.sv
/* e-link receive checker: watches frame_valid, compares each frame
   with the expected one and counts the failures */
`timescale 1ns/1ns
`default_nettype none

module elink_rx_checker (
  input logic              bit_clk,
  input logic              rst_n,
  input frame_pkg::frame_t frame,
  input logic              frame_valid
);
  import frame_pkg::*;

  frame_t exp_q[$];        // Expected frames in send order
  frame_t exp_f;
  int     value_errs = 0;
  int     unexpected = 0;
  int     missing    = 0;

  // Expected frame: bad symbols are dropped, bytes past max_bytes set err
  function automatic frame_t ref_frame(input logic [15:0][7:0] bytes, input int n,
                                       input int bad_idx);
    frame_t f;
    f = '0;
    for (int i = 0; i < n; i++) begin
      if (i == bad_idx) begin
        f.err = 1'b1;
      end else if (f.len < max_bytes) begin
        f.payload[f.len] = bytes[i];
        f.len = f.len + 4'd1;
      end else begin
        f.err = 1'b1;
      end
    end
    return f;
  endfunction

  task automatic expect_frame(input logic [15:0][7:0] bytes, input int n, input int bad_idx);
    exp_q.push_back(ref_frame(bytes, n, bad_idx));
  endtask

  // Bytes past the length are expected to read as zero
  function automatic bit frame_matches(input frame_t got, input frame_t exp);
    return (got === exp);
  endfunction

  always @(negedge bit_clk) begin
    if (rst_n && frame_valid) begin
      if (exp_q.size() == 0) begin
        unexpected++;
        $display("A frame came out at %0t ns although no frame was sent for it", $time);
      end else begin
        exp_f = exp_q.pop_front();
        if (!frame_matches(frame, exp_f)) begin
          value_errs++;
          $display("ERROR %0t ns: frame len=%0d err=%b payload=%h, expected len=%0d err=%b payload=%h",
                   $time, frame.len, frame.err, frame.payload,
                   exp_f.len, exp_f.err, exp_f.payload);
        end
      end
    end
  end

  task automatic report_missing();
    missing = exp_q.size();
    if (missing != 0) begin
      $display("%0d sent frame(s) never came out of the DUT", missing);
    end
  endtask

endmodule

`default_nettype wire

// File: elink_rx_top.sv
/* e-link receive top: deserializer, 8b10b sub-block decoders,
   symbol merger and frame assembler */
`timescale 1ns/1ns
`default_nettype none

module elink_rx_top (
  input  logic              bit_clk,
  input  logic              rst_n,
  input  logic [1:0]        rx_2bit,
  output logic              locked,
  output frame_pkg::frame_t frame,
  output logic              frame_valid
);
  import elink_pkg::*;

  sym10_t     sym;
  logic       sym_valid;
  logic [4:0] data5;
  logic       valid6;
  logic [1:0] disp6;
  logic [2:0] data3;
  logic       valid4;
  logic [1:0] disp4;
  logic       is_k28;
  dec_sym_t   dsym;
  logic       dsym_valid;

  elink_deser u_deser (
    .bit_clk   (bit_clk),
    .rst_n     (rst_n),
    .rx_2bit   (rx_2bit),
    .sym       (sym),
    .sym_valid (sym_valid),
    .locked    (locked)
  );

  dec_6b5b u_dec6 (
    .code6 (sym[9:4]),
    .data5 (data5),
    .valid (valid6),
    .disp  (disp6)
  );

  dec_4b3b u_dec4 (
    .code4  (sym[3:0]),
    .is_k28 (is_k28),
    .data3  (data3),
    .valid  (valid4),
    .disp   (disp4)
  );

  symbol_merge u_merge (
    .bit_clk    (bit_clk),
    .rst_n      (rst_n),
    .sym        (sym),
    .sym_valid  (sym_valid),
    .data5      (data5),
    .valid6     (valid6),
    .disp6      (disp6),
    .data3      (data3),
    .valid4     (valid4),
    .disp4      (disp4),
    .is_k28     (is_k28),
    .dsym       (dsym),
    .dsym_valid (dsym_valid)
  );

  frame_assembler u_asm (
    .bit_clk     (bit_clk),
    .rst_n       (rst_n),
    .dsym        (dsym),
    .dsym_valid  (dsym_valid),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

endmodule

`default_nettype wire

// File: flist.f
elink_pkg.sv
frame_pkg.sv
elink_deser.sv
dec_6b5b.sv
dec_4b3b.sv
symbol_merge.sv
frame_assembler.sv
elink_rx_top.sv
elink_rx_checker.sv
tb_elink_rx.sv

// File: frame_assembler.sv
/* Frame assembler: collects data bytes between K28.1 and K28.6 and
   reports each frame with length and error flag */
`timescale 1ns/1ns
`default_nettype none

module frame_assembler (
  input  logic                bit_clk,
  input  logic                rst_n,
  input  elink_pkg::dec_sym_t dsym,
  input  logic                dsym_valid,
  output frame_pkg::frame_t   frame,
  output logic                frame_valid
);
  import elink_pkg::*;
  import frame_pkg::*;

  asm_state_e                state_q;
  logic [max_bytes-1:0][7:0] payload_q;
  logic [3:0]                len_q;
  logic                      err_q;
  logic                      bad;
  logic                      start;
  logic                      is_eof;
  logic                      data_in;   // Data byte inside a frame
  logic                      store;

  assign bad     = dsym.code_err || dsym.disp_err;
  assign start   = dsym_valid && !bad && dsym.is_k && (dsym.data == k28_1_val);
  assign is_eof  = dsym.is_k && (dsym.data == k28_6_val);
  assign data_in = dsym_valid && !bad && !dsym.is_k && (state_q == in_frame);
  assign store   = data_in && (len_q < 4'(max_bytes));

  always_ff @(posedge bit_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= idle;
      len_q       <= '0;
      err_q       <= 1'b0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      if (start) begin
        state_q <= in_frame;   // Also restarts an open frame
        len_q   <= '0;
        err_q   <= 1'b0;
      end else if (state_q == in_frame && dsym_valid) begin
        if (bad) begin
          err_q <= 1'b1;
        end else if (is_eof) begin
          state_q     <= idle;
          frame_valid <= 1'b1;
        end else if (store) begin
          len_q <= len_q + 4'd1;
        end else if (data_in) begin
          err_q <= 1'b1;       // Byte past the payload limit
        end
      end
    end
  end

  // Unused bytes read as zero
  always_ff @(posedge bit_clk) begin
    if (start) begin
      payload_q <= '0;
    end else if (store) begin
      payload_q[len_q[2:0]] <= dsym.data;
    end
  end

  // Held stable until the next start, at least 5 cycles away
  always_comb begin
    frame.payload = payload_q;
    frame.len     = len_q;
    frame.err     = err_q;
  end

  a_frame_pulse: assert property (@(posedge bit_clk) disable iff (!rst_n)
    frame_valid |=> !frame_valid);

endmodule

`default_nettype wire

// File: frame_pkg.sv
/* Frame-level types for the e-link receiver: frame record and
   assembler states */
`default_nettype none

package frame_pkg;

  localparam int max_bytes = 8;  // Payload limit per frame

  // Byte 0 holds the first payload byte received
  typedef struct packed {
    logic [max_bytes-1:0][7:0] payload;
    logic [3:0]                len;
    logic                      err;
  } frame_t;

  typedef enum logic {
    idle,
    in_frame
  } asm_state_e;

endpackage

`default_nettype wire

// File: symbol_merge.sv
/* Symbol merger: joins both sub-block results into a byte, tracks
   running disparity and registers one decoded symbol per strobe */
`timescale 1ns/1ns
`default_nettype none

module symbol_merge (
  input  logic                bit_clk,
  input  logic                rst_n,
  input  elink_pkg::sym10_t   sym,
  input  logic                sym_valid,
  input  logic [4:0]          data5,
  input  logic                valid6,
  input  logic [1:0]          disp6,
  input  logic [2:0]          data3,
  input  logic                valid4,
  input  logic [1:0]          disp4,
  output logic                is_k28,
  output elink_pkg::dec_sym_t dsym,
  output logic                dsym_valid
);
  import elink_pkg::*;

  logic       rd_q;     // Running disparity, 1 = positive
  logic       rd_mid;   // After abcdei
  logic       rd_end;
  logic       err6;
  logic       err4;
  logic [2:0] hi3;
  dec_sym_t   dsym_d;

  assign is_k28 = (sym[9:4] == k28_5_neg[9:4]) || (sym[9:4] == ~k28_5_neg[9:4]);

  // A sub-block leaning the same way as the disparity entering it is illegal
  assign err6   = rd_q ? (disp6 == disp_pos) : (disp6 == disp_neg);
  assign rd_mid = (disp6 == disp_zero) ? rd_q : (disp6 == disp_pos);
  assign err4   = rd_mid ? (disp4 == disp_pos) : (disp4 == disp_neg);
  assign rd_end = (disp4 == disp_zero) ? rd_mid : (disp4 == disp_pos);

  // After 001111 the K28 fghj comes in data form, so undo the K-form read
  assign hi3 = (is_k28 && (disp6 == disp_pos) && (data3 inside {3'd1, 3'd2, 3'd5, 3'd6}))
               ? ~data3 : data3;

  always_comb begin
    dsym_d.data     = {hi3, is_k28 ? 5'd28 : data5};
    dsym_d.is_k     = is_k28;
    dsym_d.code_err = !(valid6 || is_k28) || !valid4;
    dsym_d.disp_err = err6 || err4;
  end

  always_ff @(posedge bit_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_q       <= 1'b0;
      dsym_valid <= 1'b0;
    end else begin
      dsym_valid <= sym_valid;
      if (sym_valid) begin
        rd_q <= rd_end;  // Follows the line even after an error
      end
    end
  end

  always_ff @(posedge bit_clk) begin
    if (sym_valid) begin
      dsym <= dsym_d;
    end
  end

  // Single-cycle output strobe, one cycle behind the deserializer
  a_dsym_follow: assert property (@(posedge bit_clk) disable iff (!rst_n)
    sym_valid |=> dsym_valid ##1 !dsym_valid);

endmodule

`default_nettype wire

// File: tb_elink_rx.sv
/* e-link receive testbench: 8b10b encoder, 2-bit lane driver,
   frame stimulus, watchdog and closing report */
`timescale 1ns/1ns
`default_nettype none

module tb_elink_rx;
  import elink_pkg::*;
  import frame_pkg::*;

  logic       bit_clk;
  logic       rst_n;
  logic [1:0] rx_2bit;
  logic       locked;
  frame_t     frame;
  logic       frame_valid;

  integer seed;
  logic   rd;          // Encoder running disparity, 1 = positive
  logic   pend_bit;
  logic   has_pend;
  int     sym_count = 0;
  int     cycles = 0;
  int     lock_errs = 0;

  elink_rx_top u_dut (
    .bit_clk     (bit_clk),
    .rst_n       (rst_n),
    .rx_2bit     (rx_2bit),
    .locked      (locked),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  elink_rx_checker u_chk (
    .bit_clk     (bit_clk),
    .rst_n       (rst_n),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  initial begin
    bit_clk = 1'b0;
    forever #50 bit_clk = ~bit_clk;
  end

  // Two bits per clock, the earlier bit on rx_2bit[1]
  task automatic push_bit(input logic b);
    if (has_pend) begin
      @(posedge bit_clk);
      #10;
      rx_2bit  = {pend_bit, b};
      has_pend = 1'b0;
    end else begin
      pend_bit = b;
      has_pend = 1'b1;
    end
  endtask

  task automatic send_sym(input sym10_t s);
    for (int i = 9; i >= 0; i--) begin
      push_bit(s[i]);
    end
    if ($countones(s[9:4]) != 3) rd = ($countones(s[9:4]) > 3);  // Follow the line
    if ($countones(s[3:0]) != 2) rd = ($countones(s[3:0]) > 2);
    sym_count++;
  endtask

  function automatic sym10_t encode_byte(input logic [7:0] b, input logic rd_in);
    logic [5:0] c6;
    logic [3:0] c4;
    logic       rd6;
    c6  = code6_table[b[4:0]];
    c4  = code4_table[b[7:5]];
    rd6 = rd_in;
    if (rd_in && (($countones(c6) != 3) || (c6 == 6'b111000))) c6 = ~c6;
    if ($countones(c6) != 3) rd6 = ($countones(c6) > 3);
    if (rd6 && (($countones(c4) != 2) || (c4 == 4'b1100))) c4 = ~c4;
    return {c6, c4};
  endfunction

  task automatic send_control(input sym10_t k_neg);
    send_sym(rd ? ~k_neg : k_neg);  // Positive form of K28.x is the full complement
  endtask

  function automatic int rand_len(input int lo, input int span);
    return lo + ($unsigned($random(seed)) % span);
  endfunction

  // kind 1 sends one byte in the wrong disparity form, kind 2 an illegal code
  task automatic send_frame(input int n, input int bad_idx, input int kind);
    logic [15:0][7:0] bytes;
    sym10_t           s;
    bytes = '0;
    for (int i = 0; i < n; i++) begin
      bytes[i] = 8'($random(seed));
    end
    if (kind == 1) bytes[bad_idx][4:0] = 5'd0;  // D.0.y is unbalanced in both forms
    u_chk.expect_frame(bytes, n, (kind != 0) ? bad_idx : -1);
    send_control(k28_1_neg);
    for (int i = 0; i < n; i++) begin
      s = encode_byte(bytes[i], rd);
      if (kind == 1 && i == bad_idx) s = encode_byte(bytes[i], !rd);
      if (kind == 2 && i == bad_idx) s = 10'b000000_1011;
      send_sym(s);
    end
    send_control(k28_6_neg);
    send_control(k28_5_neg);
    send_control(k28_5_neg);
  endtask

  task automatic inject_noise();
    repeat (3) send_sym(encode_byte(8'($random(seed)), rd));
    send_control(k28_6_neg);   // Stray end delimiter
    send_control(k28_5_neg);
  endtask

  task automatic drain_idle();
    for (int i = 0; i < 10 && u_chk.exp_q.size() != 0; i++) begin
      send_control(k28_5_neg);
    end
  endtask

  task automatic start_run(input logic extra);
    rst_n    = 1'b0;
    rx_2bit  = 2'b00;
    has_pend = 1'b0;
    rd       = 1'b0;
    repeat (16) @(posedge bit_clk);
    #10;
    rst_n = 1'b1;
    if (locked !== 1'b0) begin
      lock_errs++;
      $display("ERROR %0t ns: locked is high right after reset", $time);
    end
    if (extra) push_bit(1'b0);  // Shifts the symbols to the other bit phase
    repeat (4) send_control(k28_5_neg);
    for (int i = 0; i < 4 && locked !== 1'b1; i++) begin
      send_control(k28_5_neg);
    end
    if (locked !== 1'b1) begin
      lock_errs++;
      $display("The deserializer never locked with %0d extra bit(s) in front", extra);
    end
  endtask

  // Limit grows with the symbols sent, plus both resets and a margin
  initial begin
    forever begin
      @(posedge bit_clk);
      cycles++;
      if (cycles > sym_count * 5 + 200 + 2 * 16) begin
        $display("The run timed out after %0d cycles with %0d symbols sent", cycles, sym_count);
        $display("Something failed");
        $finish;
      end
    end
  end

  initial begin
    seed = 32'h7be5_2789;
    start_run(1'b0);
    repeat (6) send_frame(rand_len(1, 8), -1, 0);
    send_frame(0, -1, 0);
    inject_noise();
    send_frame(rand_len(9, 4), -1, 0);  // Overflow
    send_frame(rand_len(1, 8), -1, 0);
    drain_idle();

    start_run(1'b1);
    inject_noise();
    repeat (2) send_frame(rand_len(1, 8), -1, 0);
    send_frame(5, rand_len(0, 5), 1);
    send_frame(4, 1, 2);
    repeat (3) send_frame(rand_len(1, 8), -1, 0);
    send_frame(0, -1, 0);
    drain_idle();

    u_chk.report_missing();
    $display("Errors: value %0d, unexpected frames %0d, missing frames %0d, lock %0d",
             u_chk.value_errs, u_chk.unexpected, u_chk.missing, lock_errs);
    if (u_chk.value_errs + u_chk.unexpected + u_chk.missing + lock_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
